//--- all.f
+incdir+logic
logic/spi_pkg.sv
logic/setting_reg.sv
logic/spi_regfile.sv
logic/spi_engine.sv
logic/spi_pad_stage.sv
logic/spi_master.sv
sim/spi_slave_model.sv
sim/spi_master_tb.sv

//--- logic/setting_reg.sv
module setting_reg #(
    parameter logic [7:0] addr        = 8'd0,
    parameter type        payload_t   = logic [31:0],
    parameter payload_t   reset_value = '0
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        set_stb,
    input  logic [7:0]  set_addr,
    input  logic [31:0] set_data,
    output payload_t    value,
    output logic        changed
);

    // payload width taken from the low end of the bus word
    localparam int payload_bits = $bits(payload_t);

    // address decode for this register
    logic hit;

    assign hit = set_stb && (set_addr == addr);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            value   <= reset_value;
            changed <= 1'b0;
        end else begin
            // one cycle pulse right after the write
            changed <= hit;
            if (hit) begin
                value <= payload_t'(set_data[payload_bits-1:0]);
            end
        end
    end

endmodule

//--- logic/spi_engine.sv
`include "spi_settings.svh"

module spi_engine (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [15:0]          divider,
    input  spi_pkg::spi_config_t spi_config,
    input  logic [31:0]          mosi_data,
    input  logic                 shutdown,
    input  logic                 trigger,
    input  logic                 miso_sync,
    output spi_pkg::spi_state_t  state,
    output logic                 sclk_next,
    output logic                 mosi_next,
    output logic                 ready,
    output logic [31:0]          readback,
    output logic                 readback_stb
);
    import spi_pkg::*;

    // divider counter ticking once per half bit
    logic [15:0] sclk_counter;
    logic [15:0] sclk_counter_next;
    logic        tick;

    // bits completed so far in this transaction
    logic [6:0]  bit_counter;
    logic [6:0]  bit_counter_next;
    logic        bit_counter_done;

    // mosi leaves the shift register at bit 31 and miso enters at bit 0
    logic [31:0] dataout_reg;
    logic [31:0] datain_reg;
    logic        in_shift;
    logic        out_shift;

    // set in wait_trig once a cycle has passed without a trigger
    logic        ready_reg;

    assign tick              = (sclk_counter == divider);
    assign sclk_counter_next = tick ? 16'd0 : sclk_counter + 16'd1;

    assign bit_counter_next = bit_counter + 7'd1;
    assign bit_counter_done = (bit_counter_next == {1'b0, spi_config.num_bits});

    // sample on the leading edge when datain_edge is away from idle,
    // otherwise on the trailing edge
    assign in_shift = tick && (
        (state == clk_reg && spi_config.datain_edge != `SPI_CLK_IDLE) ||
        (state == clk_inv && spi_config.datain_edge == `SPI_CLK_IDLE));

    // bit 31 is already on the pin for the first edge,
    // and nothing follows the last one
    assign out_shift = tick && (
        (state == clk_reg && spi_config.dataout_edge != `SPI_CLK_IDLE &&
         bit_counter != 7'd0) ||
        (state == clk_inv && spi_config.dataout_edge == `SPI_CLK_IDLE &&
         !bit_counter_done));

    assign mosi_next = dataout_reg[31];
    assign readback  = datain_reg;

    // triggers and shutdown both pull ready down in the same cycle
    assign ready = ready_reg && !trigger && !shutdown;

    // data path
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dataout_reg <= 32'd0;
            datain_reg  <= 32'd0;
        end else begin
            // transmit word follows the register while idle
            if (state == wait_trig) begin
                dataout_reg <= mosi_data;
            end else if (out_shift) begin
                dataout_reg <= {dataout_reg[30:0], 1'b0};
            end
            if (in_shift) begin
                datain_reg <= {datain_reg[30:0], miso_sync};
            end
        end
    end

    // sequencer
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state        <= wait_trig;
            sclk_next    <= `SPI_CLK_IDLE;
            ready_reg    <= 1'b0;
            readback_stb <= 1'b0;
            sclk_counter <= 16'd0;
            bit_counter  <= 7'd0;
        end else begin
            readback_stb <= 1'b0;
            ready_reg    <= 1'b0;
            case (state)
                wait_trig: begin
                    ready_reg    <= !trigger;
                    sclk_counter <= 16'd0;
                    bit_counter  <= 7'd0;
                    sclk_next    <= `SPI_CLK_IDLE;
                    // writes seen while ready was low are not queued
                    if (trigger && !shutdown && ready_reg) begin
                        state <= pre_idle;
                    end
                end
                pre_idle: begin
                    sclk_counter <= sclk_counter_next;
                    sclk_next    <= `SPI_CLK_IDLE;
                    if (tick) begin
                        state <= clk_reg;
                    end
                end
                clk_reg: begin
                    sclk_counter <= sclk_counter_next;
                    if (tick) begin
                        state     <= clk_inv;
                        sclk_next <= ~`SPI_CLK_IDLE;
                    end
                end
                clk_inv: begin
                    sclk_counter <= sclk_counter_next;
                    if (tick) begin
                        state       <= bit_counter_done ? post_idle : clk_reg;
                        bit_counter <= bit_counter_next;
                        sclk_next   <= `SPI_CLK_IDLE;
                    end
                end
                post_idle: begin
                    sclk_counter <= sclk_counter_next;
                    sclk_next    <= `SPI_CLK_IDLE;
                    if (tick) begin
                        state <= idle_sen;
                    end
                end
                idle_sen: begin
                    sclk_counter <= sclk_counter_next;
                    sclk_next    <= `SPI_CLK_IDLE;
                    // enables are idle and readback is final
                    if (tick) begin
                        readback_stb <= 1'b1;
                        state        <= wait_trig;
                    end
                end
                default: begin
                    state <= wait_trig;
                end
            endcase
        end
    end

endmodule

//--- logic/spi_master.sv
`include "spi_settings.svh"

module spi_master (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      set_stb,
    input  logic [7:0]                set_addr,
    input  logic [31:0]               set_data,
    input  logic                      miso,
    output logic [31:0]               readback,
    output logic                      readback_stb,
    output logic                      ready,
    output logic [`SPI_SEN_WIDTH-1:0] sen,
    output logic                      sclk,
    output logic                      mosi
);
    import spi_pkg::*;

    // decode stage to engine
    logic [15:0] divider;
    spi_config_t spi_config;
    logic [31:0] mosi_data;
    logic        shutdown;
    logic        trigger;

    // engine to pad stage and back
    spi_state_t  state;
    logic        sclk_next;
    logic        mosi_next;
    logic        miso_sync;

    spi_regfile regfile_i (
        .clock      (clock),
        .reset      (reset),
        .set_stb    (set_stb),
        .set_addr   (set_addr),
        .set_data   (set_data),
        .divider    (divider),
        .spi_config (spi_config),
        .mosi_data  (mosi_data),
        .shutdown   (shutdown),
        .trigger    (trigger)
    );

    spi_engine engine_i (
        .clock        (clock),
        .reset        (reset),
        .divider      (divider),
        .spi_config   (spi_config),
        .mosi_data    (mosi_data),
        .shutdown     (shutdown),
        .trigger      (trigger),
        .miso_sync    (miso_sync),
        .state        (state),
        .sclk_next    (sclk_next),
        .mosi_next    (mosi_next),
        .ready        (ready),
        .readback     (readback),
        .readback_stb (readback_stb)
    );

    spi_pad_stage pad_i (
        .clock        (clock),
        .reset        (reset),
        .state        (state),
        .slave_select (spi_config.slave_select),
        .sclk_next    (sclk_next),
        .mosi_next    (mosi_next),
        .miso         (miso),
        .sen          (sen),
        .sclk         (sclk),
        .mosi         (mosi),
        .miso_sync    (miso_sync)
    );

endmodule

//--- logic/spi_pad_stage.sv
`include "spi_settings.svh"

module spi_pad_stage (
    input  logic                      clock,
    input  logic                      reset,
    input  spi_pkg::spi_state_t       state,
    input  logic [23:0]               slave_select,
    input  logic                      sclk_next,
    input  logic                      mosi_next,
    input  logic                      miso,
    output logic [`SPI_SEN_WIDTH-1:0] sen,
    output logic                      sclk,
    output logic                      mosi,
    output logic                      miso_sync
);
    import spi_pkg::*;

    // idle pattern of all 24 enables
    localparam logic [23:0] sen_idle = `SPI_SEN_IDLE;

    logic        sen_is_idle;
    logic [23:0] sen_full;
    // first flop behind the miso pad
    logic        miso_meta;

    // enables released while waiting and in the last idle phase
    assign sen_is_idle = (state == wait_trig) || (state == idle_sen);
    assign sen_full    = sen_is_idle ? sen_idle : (sen_idle ^ slave_select);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sen  <= sen_idle[`SPI_SEN_WIDTH-1:0];
            sclk <= `SPI_CLK_IDLE;
        end else begin
            sen  <= sen_full[`SPI_SEN_WIDTH-1:0];
            sclk <= sclk_next;
        end
    end

    // pad registers on the data pins
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mosi      <= 1'b0;
            miso_meta <= 1'b0;
            miso_sync <= 1'b0;
        end else begin
            mosi      <= mosi_next;
            miso_meta <= miso;
            miso_sync <= miso_meta;
        end
    end

endmodule

//--- logic/spi_pkg.sv
package spi_pkg;

    // configuration word as written on the settings bus
    // fields from the msb down are dataout edge, datain edge, bit count and slave select
    typedef struct packed {
        // 1 = output bit changes on the edge away from idle
        logic        dataout_edge;
        // 1 = input bit latched on the edge away from idle
        logic        datain_edge;
        // 1 through 32
        logic [5:0]  num_bits;
        // bit 0 selects slave 0
        logic [23:0] slave_select;
    } spi_config_t;

    // transaction sequencer states
    typedef enum logic [2:0] {
        // idle and waiting for a transmit write
        wait_trig = 3'd0,
        // enables asserted with sclk still idle
        pre_idle  = 3'd1,
        // first half of a bit with sclk at idle level
        clk_reg   = 3'd2,
        // second half of a bit with sclk inverted
        clk_inv   = 3'd3,
        // last bit done and enables still asserted
        post_idle = 3'd4,
        // enables released before ready returns
        idle_sen  = 3'd5
    } spi_state_t;

endpackage

//--- logic/spi_regfile.sv
`include "spi_settings.svh"

module spi_regfile (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 set_stb,
    input  logic [7:0]           set_addr,
    input  logic [31:0]          set_data,
    output logic [15:0]          divider,
    output spi_pkg::spi_config_t spi_config,
    output logic [31:0]          mosi_data,
    output logic                 shutdown,
    output logic                 trigger
);
    import spi_pkg::*;

    // sclk divider
    setting_reg #(
        .addr        (`SPI_DIVIDER_ADDR),
        .payload_t   (logic [15:0]),
        .reset_value (16'd0)
    ) divider_reg (
        .clock    (clock),
        .reset    (reset),
        .set_stb  (set_stb),
        .set_addr (set_addr),
        .set_data (set_data),
        .value    (divider),
        .changed  ()
    );

    // slave select, bit count and edge selection
    setting_reg #(
        .addr        (`SPI_CONFIG_ADDR),
        .payload_t   (spi_config_t),
        .reset_value ('0)
    ) config_reg (
        .clock    (clock),
        .reset    (reset),
        .set_stb  (set_stb),
        .set_addr (set_addr),
        .set_data (set_data),
        .value    (spi_config),
        .changed  ()
    );

    // the write pulse of the transmit word starts the engine
    setting_reg #(
        .addr        (`SPI_DATA_ADDR),
        .payload_t   (logic [31:0]),
        .reset_value (32'd0)
    ) data_reg (
        .clock    (clock),
        .reset    (reset),
        .set_stb  (set_stb),
        .set_addr (set_addr),
        .set_data (set_data),
        .value    (mosi_data),
        .changed  (trigger)
    );

    // shutdown comes up cleared so the core runs after reset
    setting_reg #(
        .addr        (`SPI_SHUTDOWN_ADDR),
        .payload_t   (logic),
        .reset_value (1'b0)
    ) shutdown_reg (
        .clock    (clock),
        .reset    (reset),
        .set_stb  (set_stb),
        .set_addr (set_addr),
        .set_data (set_data),
        .value    (shutdown),
        .changed  ()
    );

endmodule

//--- logic/spi_settings.svh
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// settings bus register map of four words from the base
`define SPI_BASE_ADDR 8'h00
// sclk divider giving a half period of divider+1 clocks
`define SPI_DIVIDER_ADDR (`SPI_BASE_ADDR + 8'd0)
// slave select, bit count and edges
`define SPI_CONFIG_ADDR (`SPI_BASE_ADDR + 8'd1)
// transmit word, a write starts a transaction
`define SPI_DATA_ADDR (`SPI_BASE_ADDR + 8'd2)
// shutdown bit
`define SPI_SHUTDOWN_ADDR (`SPI_BASE_ADDR + 8'd3)

// number of serial enables brought out (at most 24)
`define SPI_SEN_WIDTH 8

// pin levels between transactions
`define SPI_CLK_IDLE 1'b0
`define SPI_SEN_IDLE 24'hffffff

`endif

//--- sim/spi_master_tb.sv
`include "spi_settings.svh"

module spi_master_tb;
    import spi_pkg::*;

    // 40 transactions at the largest divider of 6
    localparam int cycle_limit = 40 * (34 * 2 * (6 + 1) + 10);
    // enable pattern with no slave selected
    localparam logic [23:0] sen_idle_full = `SPI_SEN_IDLE;

    logic clock, reset, set_stb, miso, readback_stb, ready, sclk, mosi;
    logic [7:0]  set_addr;
    logic [31:0] set_data, readback, received, reply, rng;
    logic [`SPI_SEN_WIDTH-1:0] sen;
    logic [6:0]  bit_count;
    logic [5:0]  num_bits;
    logic        datain_edge, dataout_edge, in_txn, stb_seen, last_sclk;
    logic [15:0] divider;
    // enable pattern expected while the current slave is selected
    logic [23:0] sen_selected;
    int errors, cycles, toggles, last_toggle;

    spi_master spi_master_i (
        .clock(clock), .reset(reset), .set_stb(set_stb), .set_addr(set_addr),
        .set_data(set_data), .miso(miso), .readback(readback),
        .readback_stb(readback_stb), .ready(ready), .sen(sen), .sclk(sclk), .mosi(mosi)
    );

    spi_slave_model slave_i (
        .sen(sen[0]), .sclk(sclk), .mosi(mosi), .num_bits(num_bits),
        .datain_edge(datain_edge), .dataout_edge(dataout_edge), .reply(reply),
        .miso(miso), .received(received), .bit_count(bit_count)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clock);
        #1 set_stb = 1'b1;
        set_addr = addr;
        set_data = data;
        @(posedge clock);
        #1 set_stb = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clock);
    endtask

    // one transfer with an optional second transmit write landing mid-transfer
    task automatic run_transfer(input logic [31:0] data, input logic [5:0] n,
                                input logic din, input logic dout, input logic double_write);
        spi_config_t cfg;
        logic [31:0] mask;
        rng = xorshift(rng);
        cfg.slave_select = {16'd0, rng[7:1], 1'b1};
        cfg.num_bits     = n;
        cfg.datain_edge  = din;
        cfg.dataout_edge = dout;
        sen_selected = `SPI_SEN_IDLE ^ cfg.slave_select;
        num_bits     = n;
        datain_edge  = din;
        dataout_edge = dout;
        rng   = xorshift(rng);
        reply = rng;
        mask  = 32'((64'd1 << n) - 64'd1);
        write_setting(`SPI_CONFIG_ADDR, cfg);
        while (!ready) @(negedge clock);
        toggles  = 0;
        stb_seen = 1'b0;
        write_setting(`SPI_DATA_ADDR, data);
        in_txn = 1'b1;
        if (double_write) begin
            wait_cycles(5);
            write_setting(`SPI_DATA_ADDR, ~data);
        end
        while (!stb_seen) @(negedge clock);
        assert (received == (data >> (32 - n))) else begin
            errors++;
            $display("** Error at %0t: slave got %h, expected %h", $time, received,
                     data >> (32 - n));
        end
        assert (bit_count == n) else begin
            errors++;
            $display("** Error at %0t: slave counted %0d bits, expected %0d", $time,
                     bit_count, n);
        end
        assert ((readback & mask) == (reply & mask)) else begin
            errors++;
            $display("** Error at %0t: readback %h, expected %h", $time,
                     readback & mask, reply & mask);
        end
        assert (toggles == 2 * n) else begin
            errors++;
            $display("** Error at %0t: %0d sclk toggles, expected %0d", $time, toggles, 2 * n);
        end
    endtask

    // pin checks at the falling clock edge where all flops are settled
    always @(negedge clock) begin
        if (!reset) begin
            if (sclk != last_sclk) begin
                if (toggles > 0) begin
                    assert (cycles - last_toggle == divider + 1) else begin
                        errors++;
                        $display("** Error at %0t: sclk half period %0d, expected %0d",
                                 $time, cycles - last_toggle, divider + 1);
                    end
                end
                // every sclk edge lies inside the selection window
                assert (sen == sen_selected[`SPI_SEN_WIDTH-1:0]) else begin
                    errors++;
                    $display("** Error at %0t: sen %h at an sclk edge, expected %h", $time,
                             sen, sen_selected[`SPI_SEN_WIDTH-1:0]);
                end
                toggles++;
                last_toggle = cycles;
            end
            last_sclk = sclk;
            if (in_txn) begin
                assert (!ready) else begin
                    errors++;
                    $display("** Error at %0t: ready high during a transfer", $time);
                end
                assert (sen == sen_idle_full[`SPI_SEN_WIDTH-1:0] ||
                        sen == sen_selected[`SPI_SEN_WIDTH-1:0]) else begin
                    errors++;
                    $display("** Error at %0t: sen %h during transfer", $time, sen);
                end
            end else begin
                assert (sen == sen_idle_full[`SPI_SEN_WIDTH-1:0] && sclk == `SPI_CLK_IDLE)
                else begin
                    errors++;
                    $display("** Error at %0t: sen %h sclk %b while idle", $time, sen, sclk);
                end
            end
            if (readback_stb) begin
                assert (in_txn) else begin
                    errors++;
                    $display("unexpected readback_stb with no transfer running at %0t", $time);
                end
                assert (sen == sen_idle_full[`SPI_SEN_WIDTH-1:0]) else begin
                    errors++;
                    $display("** Error at %0t: sen %h not idle at readback_stb", $time, sen);
                end
                in_txn   = 1'b0;
                stb_seen = 1'b1;
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        set_stb = 1'b0;
        set_addr = 8'd0;
        set_data = 32'd0;
        num_bits = 6'd1;
        datain_edge = 1'b0;
        dataout_edge = 1'b0;
        reply = 32'd0;
        in_txn = 1'b0;
        stb_seen = 1'b0;
        last_sclk = `SPI_CLK_IDLE;
        divider = 16'd3;
        sen_selected = `SPI_SEN_IDLE;
        errors = 0;
        cycles = 0;
        toggles = 0;
        last_toggle = 0;
        rng = 32'he58907d3;
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
        wait_cycles(2);
        assert (ready && !readback_stb) else begin
            errors++;
            $display("** Error at %0t: ready %b readback_stb %b after reset", $time,
                     ready, readback_stb);
        end
        // random transfers over all edge pairs and both ends of the bit count
        for (int i = 0; i < 20; i++) begin
            rng = xorshift(rng);
            divider = 16'd3 + 16'(rng[1:0]);
            write_setting(`SPI_DIVIDER_ADDR, {16'd0, divider});
            rng = xorshift(rng);
            run_transfer(rng, (i == 0) ? 6'd32 : (i == 1) ? 6'd1 : 6'(rng[4:0]) + 6'd1,
                         i[0], i[1], 1'b0);
        end
        // shutdown blocks the trigger
        write_setting(`SPI_SHUTDOWN_ADDR, 32'd1);
        write_setting(`SPI_DATA_ADDR, 32'ha5a5a5a5);
        for (int i = 0; i < 200; i++) begin
            @(negedge clock);
            assert (!ready) else begin
                errors++;
                $display("** Error at %0t: ready high under shutdown", $time);
            end
        end
        write_setting(`SPI_SHUTDOWN_ADDR, 32'd0);
        rng = xorshift(rng);
        run_transfer(rng, 6'd16, 1'b1, 1'b0, 1'b0);
        // a write while busy is not queued
        rng = xorshift(rng);
        run_transfer(rng, 6'd24, 1'b0, 1'b1, 1'b1);
        wait_cycles(100);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim/spi_slave_model.sv
`include "spi_settings.svh"

module spi_slave_model (
    input  logic        sen,
    input  logic        sclk,
    input  logic        mosi,
    input  logic [5:0]  num_bits,
    input  logic        datain_edge,
    input  logic        dataout_edge,
    input  logic [31:0] reply,
    output logic        miso,
    output logic [31:0] received,
    output logic [6:0]  bit_count
);

    // index of the next reply bit to put on miso
    int reply_idx;
    // sclk level away from idle marks the leading edge
    logic leading;

    initial begin
        miso      = 1'b0;
        received  = 32'd0;
        bit_count = 7'd0;
        reply_idx = 0;
    end

    // selection starts a fresh word
    always @(negedge sen) begin
        received  = 32'd0;
        bit_count = 7'd0;
        reply_idx = num_bits - 1;
        // master samples on leading edges, so the first bit must wait on the pin
        if (datain_edge) begin
            miso      = reply[reply_idx];
            reply_idx = reply_idx - 1;
        end
    end

    always @(sclk) begin
        leading = (sclk != `SPI_CLK_IDLE);
        if (!sen && sclk !== 1'bx) begin
            // capture on the edge where the master holds mosi still
            if (leading == !dataout_edge) begin
                received  = {received[30:0], mosi};
                bit_count = bit_count + 7'd1;
            end
            // reply moves on the edge opposite to the master's sample edge
            if (leading == !datain_edge && reply_idx >= 0) begin
                miso      = reply[reply_idx];
                reply_idx = reply_idx - 1;
            end
        end
    end

endmodule
